// ==== verilog/ntt_params_pkg.sv ====
// NTT parameter package
// Shared constants for the unmasked 2x2 butterfly array working
// modulo q = 8380417 with 23-bit coefficients. Holds the modulus,
// the Barrett constant, the operation mode encoding and the
// pipeline latencies of the multiplier, one butterfly unit and
// the two chained stages.

package ntt_params_pkg;

    // ------------------------------
    // Arithmetic constants
    // ------------------------------

    // Coefficient width, every value on a port is below NTT_Q
    localparam int COEFF_W = 23;

    // Modulus, 2^23 - 2^13 + 1
    localparam logic [COEFF_W-1:0] NTT_Q = 23'd8380417;

    // Barrett constant floor(2^46 / NTT_Q)
    // One bit wider than a coefficient since it sits just above 2^23
    localparam logic [COEFF_W:0] BARRETT_MU = 24'd8396807;

    // ------------------------------
    // Operation modes
    // ------------------------------

    // ct   Cooley-Tukey butterfly, forward transform
    // gs   Gentleman-Sande butterfly, inverse transform
    // pwm  Pointwise multiply, with optional accumulate
    // pwa  Pointwise add
    // pws  Pointwise subtract
    typedef enum logic [2:0] {
        ct  = 3'd0,
        gs  = 3'd1,
        pwm = 3'd2,
        pwa = 3'd3,
        pws = 3'd4
    } ntt_mode_e;

    // ------------------------------
    // Pipeline latencies in cycles
    // ------------------------------

    // Product register, Barrett estimate, final correction
    localparam int MULT_LAT = 3;

    // One butterfly unit, same in every mode
    localparam int BF_LAT = MULT_LAT + 1;

    // Two chained butterfly stages for ct and gs
    localparam int BF2X2_LAT = 2 * BF_LAT;

endpackage

// ==== verilog/ntt_mod_mult.sv ====
// Modular multiplier
// Computes a * b mod q with Barrett reduction in a three stage
// pipeline. A new operand pair can enter every cycle and the
// reduced product leaves MULT_LAT cycles later.

`timescale 1ns/1ns

module ntt_mod_mult (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               zeroize_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] a_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] b_i,
    output logic [ntt_params_pkg::COEFF_W-1:0] p_o
);

    localparam int W = ntt_params_pkg::COEFF_W;

    // Modulus widened to the remainder width
    localparam logic [W+1:0] Q_EXT = {2'b00, ntt_params_pkg::NTT_Q};

    // Full product, below q^2 so it fits in 2W bits
    logic [2*W-1:0] prod_q;

    // Barrett estimate and the low product bits it is checked against
    logic [2*W+1:0] est_full;
    logic [W:0]     qhat_q;
    logic [W+1:0]   low_q;

    // Remainder before and after the two corrections
    logic [2*W:0]   qq_full;
    logic [W+1:0]   r0;
    logic [W+1:0]   r1;
    logic [W+1:0]   r2;
    logic [W-1:0]   p_q;

    // ------------------------------
    // Combinational parts
    // ------------------------------

    // Estimate floor(floor(x / 2^22) * mu / 2^24)
    // Undershoots the true quotient by at most two
    assign est_full = prod_q[2*W-1:W-1] * ntt_params_pkg::BARRETT_MU;

    // Remainder is below 3q, so 25 low bits carry it exactly
    assign qq_full = qhat_q * ntt_params_pkg::NTT_Q;
    assign r0      = low_q - qq_full[W+1:0];

    // Up to two subtractions of q bring it into [0, q)
    assign r1 = (r0 >= Q_EXT) ? (r0 - Q_EXT) : r0;
    assign r2 = (r1 >= Q_EXT) ? (r1 - Q_EXT) : r1;

    // ------------------------------
    // Pipeline registers
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '0;
            qhat_q <= '0;
            low_q  <= '0;
            p_q    <= '0;
        end else if (zeroize_i) begin
            prod_q <= '0;
            qhat_q <= '0;
            low_q  <= '0;
            p_q    <= '0;
        end else begin
            // Stage 1 full product
            prod_q <= a_i * b_i;
            // Stage 2 quotient estimate and low bits
            qhat_q <= est_full[2*W+1:W+1];
            low_q  <= prod_q[W+1:0];
            // Stage 3 reduced result
            p_q    <= r2[W-1:0];
        end
    end

    assign p_o = p_q;

endmodule

// ==== verilog/ntt_butterfly.sv ====
// Butterfly unit
// One radix-2 unit for the ct and gs butterflies and the pointwise
// multiply, add and subtract modes. Modular add and subtract are
// done inline, the product comes from one Barrett multiplier, and
// delay registers line every mode up to BF_LAT cycles.

`timescale 1ns/1ns

module ntt_butterfly (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               zeroize_i,
    input  ntt_params_pkg::ntt_mode_e          mode_i,
    input  logic                               accumulate_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] u_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] v_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] w_i,
    output logic [ntt_params_pkg::COEFF_W-1:0] u_o,
    output logic [ntt_params_pkg::COEFF_W-1:0] v_o,
    output logic [ntt_params_pkg::COEFF_W-1:0] pw_res_o
);

    localparam int W        = ntt_params_pkg::COEFF_W;
    localparam int MULT_LAT = ntt_params_pkg::MULT_LAT;
    localparam int BF_LAT   = ntt_params_pkg::BF_LAT;

    // ------------------------------
    // Modular helpers
    // ------------------------------

    // Sum of two reduced values, one correction
    function automatic logic [W-1:0] mod_add(
        input logic [W-1:0] a,
        input logic [W-1:0] b
    );
        logic [W:0] s;
        logic [W:0] s_red;
        s     = {1'b0, a} + {1'b0, b};
        s_red = s - {1'b0, ntt_params_pkg::NTT_Q};
        return (s >= {1'b0, ntt_params_pkg::NTT_Q}) ? s_red[W-1:0] : s[W-1:0];
    endfunction

    // Difference of two reduced values, add q back on borrow
    function automatic logic [W-1:0] mod_sub(
        input logic [W-1:0] a,
        input logic [W-1:0] b
    );
        logic [W:0] d;
        d = {1'b0, a} - {1'b0, b};
        if (a < b) begin
            d = d + {1'b0, ntt_params_pkg::NTT_Q};
        end
        return d[W-1:0];
    endfunction

    // First stage add/sub, sum path also carries pwa and pws results
    logic [W-1:0] sum_d;
    logic [W-1:0] diff_q;
    logic [BF_LAT-2:0][W-1:0] sum_dly;

    // Balancing delays for u and w, index 0 is one cycle old
    logic [MULT_LAT-1:0][W-1:0] u_dly;
    logic [MULT_LAT-1:0][W-1:0] w_dly;

    // Multiplier operands and result
    logic [W-1:0] mult_a;
    logic [W-1:0] mult_b;
    logic [W-1:0] prod;

    // Final stage
    logic [W-1:0] u_res_d;
    logic [W-1:0] v_res_d;
    logic [W-1:0] pw_res_d;
    logic [W-1:0] u_res_q;
    logic [W-1:0] v_res_q;
    logic [W-1:0] pw_res_q;

    // pws uses the difference, gs and pwa the sum
    assign sum_d = (mode_i == ntt_params_pkg::pws) ? mod_sub(u_i, v_i) : mod_add(u_i, v_i);

    // ------------------------------
    // Multiplier operand select
    // ------------------------------
    always_comb begin
        case (mode_i)
            // gs multiplies one cycle late, after the difference is registered
            ntt_params_pkg::gs: begin
                mult_a = diff_q;
                mult_b = w_dly[0];
            end
            ntt_params_pkg::pwm: begin
                mult_a = u_i;
                mult_b = v_i;
            end
            default: begin
                mult_a = v_i;
                mult_b = w_i;
            end
        endcase
    end

    ntt_mod_mult mult_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mult_a),
        .b_i       (mult_b),
        .p_o       (prod)
    );

    // ------------------------------
    // Final stage results
    // ------------------------------
    always_comb begin
        u_res_d  = '0;
        v_res_d  = '0;
        pw_res_d = '0;
        case (mode_i)
            ntt_params_pkg::ct: begin
                u_res_d = mod_add(u_dly[MULT_LAT-1], prod);
                v_res_d = mod_sub(u_dly[MULT_LAT-1], prod);
            end
            // v result of gs is the product itself
            ntt_params_pkg::gs: begin
                u_res_d = sum_dly[BF_LAT-2];
            end
            ntt_params_pkg::pwm: begin
                pw_res_d = mod_add(prod, accumulate_i ? w_dly[MULT_LAT-1] : '0);
            end
            ntt_params_pkg::pwa, ntt_params_pkg::pws: begin
                pw_res_d = sum_dly[BF_LAT-2];
            end
            default: begin
                pw_res_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            diff_q   <= '0;
            sum_dly  <= '0;
            u_dly    <= '0;
            w_dly    <= '0;
            u_res_q  <= '0;
            v_res_q  <= '0;
            pw_res_q <= '0;
        end else if (zeroize_i) begin
            diff_q   <= '0;
            sum_dly  <= '0;
            u_dly    <= '0;
            w_dly    <= '0;
            u_res_q  <= '0;
            v_res_q  <= '0;
            pw_res_q <= '0;
        end else begin
            diff_q   <= mod_sub(u_i, v_i);
            sum_dly  <= {sum_dly[BF_LAT-3:0], sum_d};
            u_dly    <= {u_dly[MULT_LAT-2:0], u_i};
            w_dly    <= {w_dly[MULT_LAT-2:0], w_i};
            u_res_q  <= u_res_d;
            v_res_q  <= v_res_d;
            pw_res_q <= pw_res_d;
        end
    end

    assign u_o      = u_res_q;
    // Product register already lands at BF_LAT in gs
    assign v_o      = (mode_i == ntt_params_pkg::gs) ? prod : v_res_q;
    assign pw_res_o = pw_res_q;

endmodule

// ==== verilog/ntt_butterfly_2x2.sv ====
// 2x2 butterfly array
// Two first stage butterfly units feed two second stage units for
// the ct and gs transforms. In the pointwise modes the second stage
// takes its operands straight from the inputs, so all four units
// run side by side. Twiddles for the second stage and the valid
// flag are delayed to line up with the data.

`timescale 1ns/1ns

module ntt_butterfly_2x2 (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               zeroize_i,
    input  ntt_params_pkg::ntt_mode_e          mode_i,
    input  logic                               accumulate_i,
    input  logic                               valid_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] u00_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] v00_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] w00_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] u01_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] v01_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] w01_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] u10_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] v10_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] w10_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] u11_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] v11_i,
    input  logic [ntt_params_pkg::COEFF_W-1:0] w11_i,
    output logic                               valid_o,
    output logic [ntt_params_pkg::COEFF_W-1:0] u20_o,
    output logic [ntt_params_pkg::COEFF_W-1:0] v20_o,
    output logic [ntt_params_pkg::COEFF_W-1:0] u21_o,
    output logic [ntt_params_pkg::COEFF_W-1:0] v21_o,
    output logic [ntt_params_pkg::COEFF_W-1:0] pw0_o,
    output logic [ntt_params_pkg::COEFF_W-1:0] pw1_o,
    output logic [ntt_params_pkg::COEFF_W-1:0] pw2_o,
    output logic [ntt_params_pkg::COEFF_W-1:0] pw3_o
);

    localparam int W         = ntt_params_pkg::COEFF_W;
    localparam int BF_LAT    = ntt_params_pkg::BF_LAT;
    localparam int BF2X2_LAT = ntt_params_pkg::BF2X2_LAT;

    // Any of pwm, pwa, pws
    logic pw_mode;

    // Stage 1 results before the cross connection
    logic [W-1:0] u10_int;
    logic [W-1:0] u11_int;
    logic [W-1:0] v10_int;
    logic [W-1:0] v11_int;

    // Stage 2 operands after the input select
    logic [W-1:0] u10;
    logic [W-1:0] v10;
    logic [W-1:0] w10;
    logic [W-1:0] u11;
    logic [W-1:0] v11;
    logic [W-1:0] w11;

    // Twiddle delay lines, index 0 is one cycle old
    logic [BF_LAT-1:0][W-1:0] w10_dly;
    logic [BF_LAT-1:0][W-1:0] w11_dly;

    // Valid delay line, covers the full two stage depth
    logic [BF2X2_LAT-1:0] valid_dly;

    assign pw_mode = mode_i inside {ntt_params_pkg::pwm, ntt_params_pkg::pwa,
                                    ntt_params_pkg::pws};

    // ------------------------------
    // Twiddle and valid delays
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_dly   <= '0;
            w11_dly   <= '0;
            valid_dly <= '0;
        end else if (zeroize_i) begin
            w10_dly   <= '0;
            w11_dly   <= '0;
            valid_dly <= '0;
        end else begin
            // Second stage twiddles wait out the first stage
            w10_dly   <= {w10_dly[BF_LAT-2:0], w10_i};
            w11_dly   <= {w11_dly[BF_LAT-2:0], w11_i};
            valid_dly <= {valid_dly[BF2X2_LAT-2:0], valid_i};
        end
    end

    // Pointwise results leave after one stage, transforms after two
    assign valid_o = pw_mode ? valid_dly[BF_LAT-1] : valid_dly[BF2X2_LAT-1];

    // ------------------------------
    // Stage 2 input select
    // ------------------------------
    always_comb begin
        if (pw_mode) begin
            u10 = u10_i;
            v10 = v10_i;
            w10 = w10_i;
            u11 = u11_i;
            v11 = v11_i;
            w11 = w11_i;
        end else begin
            // Cross connection of the stage 1 results
            u10 = u10_int;
            v10 = v10_int;
            w10 = w10_dly[BF_LAT-1];
            u11 = u11_int;
            v11 = v11_int;
            w11 = w11_dly[BF_LAT-1];
        end
    end

    // ------------------------------
    // Stage 1 units
    // ------------------------------
    ntt_butterfly bf00_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (u00_i),
        .v_i          (v00_i),
        .w_i          (w00_i),
        .u_o          (u10_int),
        .v_o          (u11_int),
        .pw_res_o     (pw0_o)
    );

    ntt_butterfly bf01_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (u01_i),
        .v_i          (v01_i),
        .w_i          (w01_i),
        .u_o          (v10_int),
        .v_o          (v11_int),
        .pw_res_o     (pw1_o)
    );

    // ------------------------------
    // Stage 2 units
    // ------------------------------
    ntt_butterfly bf10_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (u10),
        .v_i          (v10),
        .w_i          (w10),
        .u_o          (u20_o),
        .v_o          (v20_o),
        .pw_res_o     (pw2_o)
    );

    ntt_butterfly bf11_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .u_i          (u11),
        .v_i          (v11),
        .w_i          (w11),
        .u_o          (u21_o),
        .v_o          (v21_o),
        .pw_res_o     (pw3_o)
    );

endmodule

// ==== testbench/ntt_ref_model.svh ====
// NTT reference model
// Integer reference for the 2x2 butterfly array. Modular add,
// subtract and multiply mod q in 64-bit arithmetic, the expected
// outputs of one item in every mode, and a 16-bit Fibonacci LFSR
// step for the stimulus.

`ifndef NTT_REF_MODEL_SVH
`define NTT_REF_MODEL_SVH

// ------------------------------
// Modular arithmetic
// ------------------------------

// Sum mod q
function automatic logic [ntt_params_pkg::COEFF_W-1:0] add_mod(
    input logic [ntt_params_pkg::COEFF_W-1:0] a,
    input logic [ntt_params_pkg::COEFF_W-1:0] b
);
    longint r;
    r = (longint'(a) + longint'(b)) % longint'(ntt_params_pkg::NTT_Q);
    return r[ntt_params_pkg::COEFF_W-1:0];
endfunction

// Difference mod q, q added first so it never goes negative
function automatic logic [ntt_params_pkg::COEFF_W-1:0] sub_mod(
    input logic [ntt_params_pkg::COEFF_W-1:0] a,
    input logic [ntt_params_pkg::COEFF_W-1:0] b
);
    longint r;
    r = (longint'(a) + longint'(ntt_params_pkg::NTT_Q) - longint'(b))
        % longint'(ntt_params_pkg::NTT_Q);
    return r[ntt_params_pkg::COEFF_W-1:0];
endfunction

// Product mod q, below 2^46 before the reduction
function automatic logic [ntt_params_pkg::COEFF_W-1:0] mul_mod(
    input logic [ntt_params_pkg::COEFF_W-1:0] a,
    input logic [ntt_params_pkg::COEFF_W-1:0] b
);
    longint r;
    r = (longint'(a) * longint'(b)) % longint'(ntt_params_pkg::NTT_Q);
    return r[ntt_params_pkg::COEFF_W-1:0];
endfunction

// ------------------------------
// Expected outputs of one item
// ------------------------------

// Coefficient order u00 v00 w00 u01 v01 w01 u10 v10 w10 u11 v11 w11
// Result order u20 v20 u21 v21 for ct and gs, pw0 to pw3 otherwise
function automatic logic [3:0][ntt_params_pkg::COEFF_W-1:0] expected_outputs(
    input ntt_params_pkg::ntt_mode_e                    mode,
    input logic                                         acc,
    input logic [11:0][ntt_params_pkg::COEFF_W-1:0]     c
);
    logic [ntt_params_pkg::COEFF_W-1:0]       a0;
    logic [ntt_params_pkg::COEFF_W-1:0]       b0;
    logic [ntt_params_pkg::COEFF_W-1:0]       a1;
    logic [ntt_params_pkg::COEFF_W-1:0]       b1;
    logic [3:0][ntt_params_pkg::COEFF_W-1:0] r;
    int k;
    r = '0;
    case (mode)
        ntt_params_pkg::ct: begin
            // First stage on pairs 00 and 01, then crossed second stage
            a0 = add_mod(c[0], mul_mod(c[1], c[2]));
            b0 = sub_mod(c[0], mul_mod(c[1], c[2]));
            a1 = add_mod(c[3], mul_mod(c[4], c[5]));
            b1 = sub_mod(c[3], mul_mod(c[4], c[5]));
            r[0] = add_mod(a0, mul_mod(a1, c[8]));
            r[1] = sub_mod(a0, mul_mod(a1, c[8]));
            r[2] = add_mod(b0, mul_mod(b1, c[11]));
            r[3] = sub_mod(b0, mul_mod(b1, c[11]));
        end
        ntt_params_pkg::gs: begin
            a0 = add_mod(c[0], c[1]);
            b0 = mul_mod(sub_mod(c[0], c[1]), c[2]);
            a1 = add_mod(c[3], c[4]);
            b1 = mul_mod(sub_mod(c[3], c[4]), c[5]);
            r[0] = add_mod(a0, a1);
            r[1] = mul_mod(sub_mod(a0, a1), c[8]);
            r[2] = add_mod(b0, b1);
            r[3] = mul_mod(sub_mod(b0, b1), c[11]);
        end
        default: begin
            // Pointwise, one result per coefficient triple
            for (k = 0; k < 4; k++) begin
                if (mode == ntt_params_pkg::pwm) begin
                    r[k] = add_mod(mul_mod(c[3*k], c[3*k+1]), acc ? c[3*k+2] : '0);
                end else if (mode == ntt_params_pkg::pwa) begin
                    r[k] = add_mod(c[3*k], c[3*k+1]);
                end else begin
                    r[k] = sub_mod(c[3*k], c[3*k+1]);
                end
            end
        end
    endcase
    return r;
endfunction

// ------------------------------
// Stimulus LFSR
// ------------------------------

// Fibonacci form, taps 16 14 13 11, new bit enters at bit 0
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

`endif

// ==== testbench/tb_ntt_butterfly_2x2.sv ====
// Testbench for the 2x2 NTT butterfly array
// Drives ct, gs and the pointwise modes with LFSR stimulus, keeps
// the expected results in a scoreboard queue and compares them on
// every valid_o, including the latency of each item.

`timescale 1ns/1ns

module tb_ntt_butterfly_2x2;

    localparam int W         = ntt_params_pkg::COEFF_W;
    localparam int BF_LAT    = ntt_params_pkg::BF_LAT;
    localparam int BF2X2_LAT = ntt_params_pkg::BF2X2_LAT;
    localparam int TIMEOUT   = 400;
    localparam logic [W-1:0] Q_MAX = ntt_params_pkg::NTT_Q - 1;

    `include "ntt_ref_model.svh"

    logic                      clk;
    logic                      reset_n;
    logic                      zeroize_i;
    ntt_params_pkg::ntt_mode_e mode_i;
    logic                      accumulate_i;
    logic                      valid_i;
    logic [11:0][W-1:0]        coef_drv;
    logic                      valid_o;
    logic [W-1:0]              u20_o;
    logic [W-1:0]              v20_o;
    logic [W-1:0]              u21_o;
    logic [W-1:0]              v21_o;
    logic [W-1:0]              pw0_o;
    logic [W-1:0]              pw1_o;
    logic [W-1:0]              pw2_o;
    logic [W-1:0]              pw3_o;

    // Next item, staged while the previous one is still driven
    logic [11:0][W-1:0] coef;
    logic [15:0]        lfsr_state = 16'd29833;
    int                 cycle_cnt  = 0;

    // Scoreboard, one entry per item sent
    logic [3:0][W-1:0] exp_q[$];
    logic              pw_q[$];
    int                cyc_q[$];

    // Counters for the per-test lines and the summary
    int err_cnt = 0;
    int check_cnt = 0;
    int sent_cnt = 0;
    int rcv_cnt = 0;
    int drop_cnt = 0;
    int tests_run = 0;
    int err_start;
    int chk_start;
    int sent_start;
    int rcv_start;
    int drop_start;

    ntt_butterfly_2x2 dut_i (
        .clk (clk), .reset_n (reset_n), .zeroize_i (zeroize_i), .mode_i (mode_i),
        .accumulate_i (accumulate_i), .valid_i (valid_i),
        .u00_i (coef_drv[0]), .v00_i (coef_drv[1]), .w00_i (coef_drv[2]),
        .u01_i (coef_drv[3]), .v01_i (coef_drv[4]), .w01_i (coef_drv[5]),
        .u10_i (coef_drv[6]), .v10_i (coef_drv[7]), .w10_i (coef_drv[8]),
        .u11_i (coef_drv[9]), .v11_i (coef_drv[10]), .w11_i (coef_drv[11]),
        .valid_o (valid_o), .u20_o (u20_o), .v20_o (v20_o), .u21_o (u21_o), .v21_o (v21_o),
        .pw0_o (pw0_o), .pw1_o (pw1_o), .pw2_o (pw2_o), .pw3_o (pw3_o)
    );

    // ------------------------------
    // Clock and cycle count
    // ------------------------------
    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // n bits from the LFSR, one step per bit
    task automatic draw_bits(input int n, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
    endtask

    // Kind 1 all zero, 2 all q-1, 3 u=0 v=q-1, else random
    task automatic fill_coef(input int kind);
        int i;
        int r;
        for (i = 0; i < 12; i++) begin
            draw_bits(W, r);
            r = r % int'(ntt_params_pkg::NTT_Q);
            case (kind)
                1: coef[i] = '0;
                2: coef[i] = Q_MAX;
                3: coef[i] = (i % 3 == 0) ? '0 : ((i % 3 == 1) ? Q_MAX : W'(r));
                default: coef[i] = W'(r);
            endcase
        end
    endtask

    task automatic send_item();
        @(posedge clk);
        #2;
        coef_drv = coef;
        valid_i  = 1'b1;
        exp_q.push_back(expected_outputs(mode_i, accumulate_i, coef));
        pw_q.push_back(mode_i inside {ntt_params_pkg::pwm, ntt_params_pkg::pwa,
                                      ntt_params_pkg::pws});
        cyc_q.push_back(cycle_cnt);
        sent_cnt++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        valid_i = 1'b0;
    endtask

    // Mode may only change with the valid line empty
    task automatic set_mode(input ntt_params_pkg::ntt_mode_e m, input logic acc);
        int i;
        for (i = 0; i < BF2X2_LAT + 2; i++) begin
            @(posedge clk);
        end
        #2;
        mode_i       = m;
        accumulate_i = acc;
    endtask

    // First three items are corner cases, gaps of 0 to 3 cycles if asked
    task automatic send_stream(input int count, input logic gaps);
        int i;
        int k;
        int g;
        for (i = 0; i < count; i++) begin
            fill_coef(i < 3 ? i + 1 : 0);
            send_item();
            if (gaps) begin
                draw_bits(2, g);
                for (k = 0; k < g; k++) begin
                    idle_cycle();
                end
            end
        end
        idle_cycle();
    endtask

    task automatic flush_queue();
        drop_cnt += exp_q.size();
        exp_q.delete();
        pw_q.delete();
        cyc_q.delete();
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("Timeout: %0d items of %s never came out on valid_o", exp_q.size(), what);
            err_cnt++;
            flush_queue();
        end
    endtask

    // ------------------------------
    // Checking and reporting
    // ------------------------------
    task automatic check_value(input string name, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("FAILED %s expected 0x%06h got 0x%06h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic test_begin();
        err_start  = err_cnt;
        chk_start  = check_cnt;
        sent_start = sent_cnt;
        rcv_start  = rcv_cnt;
        drop_start = drop_cnt;
    endtask

    task automatic test_end(input string name);
        int sent;
        int rcvd;
        sent = sent_cnt - sent_start - (drop_cnt - drop_start);
        rcvd = rcv_cnt - rcv_start;
        assert (sent == rcvd) else begin
            $display("%s sent %0d items but %0d came out on valid_o", name, sent, rcvd);
            err_cnt++;
        end
        $display("%-16s items %0d  checks %0d  errors %0d", name, rcvd,
                 check_cnt - chk_start, err_cnt - err_start);
        tests_run++;
    endtask

    // Outputs are sampled at the falling edge, well clear of both drive points
    always @(negedge clk) begin : compare_outputs
        logic [3:0][W-1:0] exp_vec;
        logic              pw;
        int                lat;
        if (reset_n && valid_o) begin
            assert (exp_q.size() != 0) else begin
                $display("valid_o high at cycle %0d with no item outstanding", cycle_cnt);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp_vec = exp_q.pop_front();
                pw      = pw_q.pop_front();
                lat     = cycle_cnt - cyc_q.pop_front();
                rcv_cnt++;
                assert (lat == (pw ? BF_LAT : BF2X2_LAT)) else begin
                    $display("Item came out after %0d cycles instead of %0d", lat,
                             pw ? BF_LAT : BF2X2_LAT);
                    err_cnt++;
                end
                if (pw) begin
                    check_value("pw0_o", pw0_o, exp_vec[0]);
                    check_value("pw1_o", pw1_o, exp_vec[1]);
                    check_value("pw2_o", pw2_o, exp_vec[2]);
                    check_value("pw3_o", pw3_o, exp_vec[3]);
                end else begin
                    check_value("u20_o", u20_o, exp_vec[0]);
                    check_value("v20_o", v20_o, exp_vec[1]);
                    check_value("u21_o", u21_o, exp_vec[2]);
                    check_value("v21_o", v21_o, exp_vec[3]);
                end
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin : run_tests
        int i;
        reset_n      = 1'b0;
        zeroize_i    = 1'b0;
        mode_i       = ntt_params_pkg::ct;
        accumulate_i = 1'b0;
        valid_i      = 1'b0;
        coef_drv     = '0;
        coef         = '0;
        repeat (5) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // Quiet after reset, then one ct item with its latency checked
        test_begin();
        for (i = 0; i < 12; i++) begin
            @(negedge clk);
            assert (!valid_o) else begin
                $display("valid_o rose after reset with no input");
                err_cnt++;
            end
        end
        fill_coef(0);
        send_item();
        idle_cycle();
        wait_drain("first ct item");
        test_end("reset_latency");

        test_begin();
        set_mode(ntt_params_pkg::ct, 1'b0);
        send_stream(64, 1'b0);
        wait_drain("ct stream");
        test_end("ct_random");

        test_begin();
        set_mode(ntt_params_pkg::gs, 1'b0);
        send_stream(64, 1'b1);
        wait_drain("gs stream");
        test_end("gs_gaps");

        test_begin();
        set_mode(ntt_params_pkg::pwm, 1'b0);
        send_stream(32, 1'b0);
        wait_drain("pwm stream");
        test_end("pwm");

        test_begin();
        set_mode(ntt_params_pkg::pwm, 1'b1);
        send_stream(32, 1'b1);
        wait_drain("pwm accumulate stream");
        test_end("pwm_accumulate");

        test_begin();
        set_mode(ntt_params_pkg::pwa, 1'b0);
        send_stream(32, 1'b0);
        wait_drain("pwa stream");
        test_end("pwa");

        test_begin();
        set_mode(ntt_params_pkg::pws, 1'b0);
        send_stream(32, 1'b1);
        wait_drain("pws stream");
        test_end("pws");

        // Zeroize with five ct items in flight
        test_begin();
        set_mode(ntt_params_pkg::ct, 1'b0);
        for (i = 0; i < 5; i++) begin
            fill_coef(0);
            send_item();
        end
        @(posedge clk);
        #2;
        valid_i   = 1'b0;
        zeroize_i = 1'b1;
        flush_queue();
        @(posedge clk);
        #2;
        assert (!valid_o) else begin
            $display("valid_o high right after zeroize");
            err_cnt++;
        end
        check_value("u20_o", u20_o, '0);
        check_value("v20_o", v20_o, '0);
        check_value("u21_o", u21_o, '0);
        check_value("v21_o", v21_o, '0);
        zeroize_i = 1'b0;
        // Nothing sent before zeroize may come out
        for (i = 0; i < BF2X2_LAT + 4; i++) begin
            @(negedge clk);
            assert (!valid_o) else begin
                $display("valid_o rose for an item sent before zeroize");
                err_cnt++;
            end
        end
        send_stream(16, 1'b0);
        wait_drain("ct stream after zeroize");
        test_end("zeroize");

        $display("Summary: %0d tests, %0d items, %0d checks, %0d errors",
                 tests_run, rcv_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+testbench
verilog/ntt_params_pkg.sv
verilog/ntt_mod_mult.sv
verilog/ntt_butterfly.sv
verilog/ntt_butterfly_2x2.sv
testbench/tb_ntt_butterfly_2x2.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the 2x2 NTT butterfly testbench with Verilator and run it.
# The exit status follows the pass message in sim.log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_ntt_butterfly_2x2 \
    -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "Verilator build error, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Test completed successfully" sim.log \
    && { echo "Simulation PASS"; exit 0; } \
    || { echo "Simulation FAIL"; exit 1; }
